/* bench/fmsynth_tb.sv */
module fmsynth_tb
    import fm_pkg::*;
;

    localparam int NUM_OPS       = 16;
    localparam int CLK_PERIOD    = 100;
    localparam int ROUND_CYCLES  = 4 * NUM_OPS + 2;
    localparam int NUM_TESTS     = 6;
    localparam int WATCHDOG_TIME = NUM_TESTS * 40 * ROUND_CYCLES * CLK_PERIOD;

    // Envelope states of the model
    localparam int M_IDLE    = 0;
    localparam int M_ATTACK  = 1;
    localparam int M_SUSTAIN = 2;
    localparam int M_RELEASE = 3;

    logic        clk;
    logic        reset;
    logic [7:0]  bus_addr;
    logic [31:0] bus_wrdata;
    logic        bus_wren;
    logic [31:0] bus_rddata;
    logic        bus_wait;
    logic [15:0] audio_l;
    logic [15:0] audio_r;
    logic        sample_valid;

    // Register shadows, written by the bus tasks
    logic [31:0]        w0_sh [NUM_OPS] = '{default: '0};
    logic [31:0]        w1_sh [NUM_OPS] = '{default: '0};
    logic [NUM_OPS-1:0] kon_sh = '0;
    // A restart is pending while the two bits differ
    logic [NUM_OPS-1:0] rst_set = '0;
    logic [NUM_OPS-1:0] rst_ack = '0;

    // Per-operator model state
    int ph_m  [NUM_OPS] = '{default: 0};
    int att_m [NUM_OPS] = '{default: 511};
    int st_m  [NUM_OPS] = '{default: 0};

    time         last_sample_time = 0;
    int          last_waits;
    time         last_accept;
    logic [31:0] lfsr_state = 32'd87763;

    fmsynth #(.NUM_OPS(NUM_OPS)) DUT (
        .clk          (clk),
        .reset        (reset),
        .bus_addr     (bus_addr),
        .bus_wrdata   (bus_wrdata),
        .bus_wren     (bus_wren),
        .bus_rddata   (bus_rddata),
        .bus_wait     (bus_wait),
        .audio_l      (audio_l),
        .audio_r      (audio_r),
        .sample_valid (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the tests did not finish in the expected number of rounds");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s, got %0d expected %0d", $time, msg,
                     $signed(actual), $signed(expected));
            $display("Test failed");
            $fatal(1, "mismatch");
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [7:0] op_addr(input int op, input int word);
        return 8'(int'(ADDR_OP_BASE) + 2 * op + word);
    endfunction

    function automatic logic [31:0] make_word0(input int fnum, input int block,
                                               input int mult, input int ws,
                                               input int pl, input int pr);
        return 32'(fnum) | (32'(block) << BLOCK_LSB) | (32'(mult) << MULT_LSB)
            | (32'(ws) << WS_LSB) | (32'(pl) << PAN_L_BIT) | (32'(pr) << PAN_R_BIT);
    endfunction

    function automatic logic [31:0] make_word1(input int tl, input int ar, input int rr);
        return 32'(tl) | (32'(ar) << AR_LSB) | (32'(rr) << RR_LSB);
    endfunction

    task automatic update_shadow(input logic [7:0] addr, input logic [31:0] data);
        int off;
        off = int'(addr) - 16;
        if (addr == 8'd0) begin
            for (int i = 0; i < NUM_OPS; i++)
                if (data[i] && !kon_sh[i] && rst_set[i] == rst_ack[i])
                    rst_set[i] = ~rst_set[i];
            kon_sh = data[NUM_OPS-1:0];
        end else if (off >= 0 && off < 2 * NUM_OPS) begin
            if (off % 2 == 1)
                w1_sh[off / 2] = data & 32'h0000_FF3F;
            else
                w0_sh[off / 2] = data & 32'h001F_FFFF;
        end
    endtask

    // Holds the request until the bus slot takes it
    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        int waits;
        waits = 0;
        @(negedge clk);
        bus_addr   = addr;
        bus_wrdata = data;
        bus_wren   = 1'b1;
        // Look at bus_wait halfway between the falling and the rising edge
        #(CLK_PERIOD / 4);
        while (bus_wait) begin
            waits++;
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        @(posedge clk);
        last_waits  = waits;
        last_accept = $time;
        update_shadow(addr, data);
        @(negedge clk);
        bus_wren = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clk);
        bus_addr = addr;
        @(posedge clk);
        data = bus_rddata;
    endtask

    task automatic wait_sample();
        do
            @(negedge clk);
        while (!sample_valid);
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic int wave_value(input int ws, input int p);
        int w;
        case (ws)
            0: w = (p < 512) ? 4095 : -4095;
            1: w = (p < 512) ? 4095 : 0;
            2: w = (p - 512) * 8;
            default: begin
                if (p < 256)
                    w = p * 16;
                else if (p < 768)
                    w = (512 - p) * 16;
                else
                    w = (p - 1024) * 16;
                if (w > 4095)
                    w = 4095;
                if (w < -4095)
                    w = -4095;
            end
        endcase
        return w;
    endfunction

    function automatic int op_result(input int i);
        int a;
        int total;
        int gain;
        a = (st_m[i] == M_IDLE) ? 511 : att_m[i];
        total = a + int'(w1_sh[i] & 32'h3F) * 8;
        gain = (total >= 511) ? 0 : 511 - total;
        return (wave_value(int'((w0_sh[i] >> WS_LSB) & 32'h3), ph_m[i] >> 9) * gain) >>> 9;
    endfunction

    task automatic step_op(input int i);
        int fnum;
        int block;
        int mult;
        int ar;
        int rr;
        int inc;
        fnum  = int'(w0_sh[i] & 32'h3FF);
        block = int'((w0_sh[i] >> BLOCK_LSB) & 32'h7);
        mult  = int'((w0_sh[i] >> MULT_LSB) & 32'hF);
        ar    = int'((w1_sh[i] >> AR_LSB) & 32'hF);
        rr    = int'((w1_sh[i] >> RR_LSB) & 32'hF);
        if (rst_set[i] != rst_ack[i]) begin
            ph_m[i]    = 0;
            att_m[i]   = 511;
            st_m[i]    = M_ATTACK;
            rst_ack[i] = rst_set[i];
        end else begin
            inc = fnum << block;
            inc = (mult == 0) ? inc >> 1 : inc * mult;
            ph_m[i] = (ph_m[i] + inc) & 32'h7FFFF;
            case (st_m[i])
                M_IDLE: att_m[i] = 511;
                M_ATTACK: begin
                    if (!kon_sh[i]) begin
                        st_m[i] = M_RELEASE;
                    end else if (ar == 15 || att_m[i] <= ar * 8) begin
                        att_m[i] = 0;
                        st_m[i]  = M_SUSTAIN;
                    end else begin
                        att_m[i] = att_m[i] - ar * 8;
                    end
                end
                M_SUSTAIN: if (!kon_sh[i]) st_m[i] = M_RELEASE;
                default: begin
                    if (att_m[i] + rr * 2 >= 511) begin
                        att_m[i] = 511;
                        st_m[i]  = M_IDLE;
                    end else begin
                        att_m[i] = att_m[i] + rr * 2;
                    end
                end
            endcase
        end
    endtask

    function automatic int clamp(input int sum);
        if (sum > 32767)
            return 32767;
        if (sum < -32768)
            return -32768;
        return sum;
    endfunction

    task automatic model_round();
        int sum_l;
        int sum_r;
        int r;
        sum_l = 0;
        sum_r = 0;
        for (int i = 0; i < NUM_OPS; i++) begin
            r = op_result(i);
            if (w0_sh[i][PAN_L_BIT])
                sum_l += r;
            if (w0_sh[i][PAN_R_BIT])
                sum_r += r;
            step_op(i);
        end
        check({{16{audio_l[15]}}, audio_l}, 32'(clamp(sum_l)), "left sample");
        check({{16{audio_r[15]}}, audio_r}, 32'(clamp(sum_r)), "right sample");
        if (last_sample_time != 0)
            check(32'($time - last_sample_time), 32'(ROUND_CYCLES * CLK_PERIOD),
                  "sample spacing");
        last_sample_time = $time;
    endtask

    // Every sample of the run goes through the model
    always @(negedge clk) begin
        if (!reset && sample_valid)
            model_round();
    end

    // Op 3 alone on a saw with ar 4 and tl 0, n rounds after its key-on is taken
    function automatic int attack_sample(input int n);
        int p;
        int att;
        if (n == 0)
            return 0;
        // Restart leaves phase 0 and attenuation 511, both step once per round
        p   = n - 1;
        att = 511 - 32 * (n - 1);
        if (att < 0)
            att = 0;
        return ((p - 512) * 8 * (511 - att)) >>> 9;
    endfunction

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task automatic test_reset_readback();
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] rd;
        int          ops [4] = '{0, 3, 7, 15};
        int          bad [4] = '{1, 15, 48, 200};
        check(32'(audio_l), 32'd0, "audio_l after reset");
        check(32'(audio_r), 32'd0, "audio_r after reset");
        check(32'(sample_valid), 32'd0, "sample_valid after reset");
        foreach (ops[k]) begin
            d0 = rand_bits(32);
            d1 = rand_bits(32);
            bus_write(op_addr(ops[k], 0), d0);
            bus_read(op_addr(ops[k], 0), rd);
            check(rd, d0 & 32'h001F_FFFF, "word 0 read-back");
            bus_write(op_addr(ops[k], 1), d1);
            bus_read(op_addr(ops[k], 1), rd);
            check(rd, d1 & 32'h0000_FF3F, "word 1 read-back");
        end
        d0 = rand_bits(32);
        bus_write(ADDR_KON, d0);
        bus_read(ADDR_KON, rd);
        check(rd, d0 & 32'h0000_FFFF, "key-on read-back");
        bus_write(ADDR_KON, 32'd0);
        foreach (bad[k]) begin
            bus_read(8'(bad[k]), rd);
            check(rd, 32'd0, "unmapped address");
        end
    endtask

    task automatic test_silence();
        time t0;
        wait_sample();
        t0 = $time;
        for (int k = 0; k < 4; k++) begin
            wait_sample();
            check(32'(audio_l), 32'd0, "silent left");
            check(32'(audio_r), 32'd0, "silent right");
        end
        check(32'($time - t0), 32'(4 * ROUND_CYCLES * CLK_PERIOD), "frame period");
    endtask

    task automatic test_single_tone();
        wave_t shapes [4] = '{WS_SQUARE, WS_SAW, WS_TRIANGLE, WS_HALF_SQUARE};
        logic [31:0] w0;
        foreach (shapes[k]) begin
            if (k == 0)
                w0 = make_word0(300, 4, 1, int'(shapes[k]), 1, 0);
            else
                w0 = make_word0(int'(rand_bits(10)), int'(rand_bits(3)),
                                int'(rand_bits(4)), int'(shapes[k]), 1, 0);
            bus_write(ADDR_KON, 32'd0);
            bus_write(op_addr(0, 0), w0);
            bus_write(op_addr(0, 1), make_word1(0, 15, 15));
            bus_write(ADDR_KON, 32'd1);
            for (int n = 0; n < 6; n++) begin
                wait_sample();
                // Round right after key-on still uses the idle state
                if (k == 0 && n == 0)
                    check(32'(audio_l), 32'd0, "first round after key-on");
                check(32'(audio_r), 32'd0, "right channel of left-only tone");
            end
        end
    endtask

    task automatic test_mix_clamp();
        bit seen_max;
        bit seen_min;
        bus_write(ADDR_KON, 32'd0);
        bus_write(op_addr(1, 0), make_word0(100, 3, 2, int'(WS_SQUARE), 1, 1));
        bus_write(op_addr(1, 1), make_word1(10, 15, 15));
        bus_write(op_addr(2, 0), make_word0(200, 2, 3, int'(WS_SAW), 0, 1));
        bus_write(op_addr(2, 1), make_word1(20, 15, 15));
        bus_write(ADDR_KON, 32'h6);
        repeat (8) wait_sample();

        // All operators in phase, the sum overflows both ways
        for (int i = 0; i < NUM_OPS; i++) begin
            bus_write(op_addr(i, 0), make_word0(512, 7, 1, int'(WS_SQUARE), 1, 0));
            bus_write(op_addr(i, 1), make_word1(0, 15, 15));
        end
        bus_write(ADDR_KON, 32'd0);
        bus_write(ADDR_KON, 32'hFFFF);
        seen_max = 1'b0;
        seen_min = 1'b0;
        for (int n = 0; n < 12; n++) begin
            wait_sample();
            if (audio_l == 16'h7FFF)
                seen_max = 1'b1;
            if (audio_l == 16'h8000)
                seen_min = 1'b1;
        end
        check(32'(seen_max), 32'd1, "left output clamped high");
        check(32'(seen_min), 32'd1, "left output clamped low");
    endtask

    task automatic test_envelope();
        bus_write(ADDR_KON, 32'd0);
        repeat (20) wait_sample();
        check(32'(audio_l), 32'd0, "all operators released");
        bus_write(op_addr(3, 0), make_word0(512, 0, 1, int'(WS_SAW), 1, 0));
        bus_write(op_addr(3, 1), make_word1(0, 4, 15));
        bus_write(ADDR_KON, 32'h8);
        for (int n = 0; n < 20; n++) begin
            wait_sample();
            check({{16{audio_l[15]}}, audio_l}, 32'(attack_sample(n)),
                  "attack after key-on");
        end
        bus_write(ADDR_KON, 32'd0);
        repeat (20) wait_sample();
        check(32'(audio_l), 32'd0, "release reached silence");
        // Phase and envelope both restart, so the attack repeats
        bus_write(ADDR_KON, 32'h8);
        for (int n = 0; n < 20; n++) begin
            wait_sample();
            check({{16{audio_l[15]}}, audio_l}, 32'(attack_sample(n)),
                  "attack after second key-on");
        end
    endtask

    task automatic test_backpressure();
        logic [31:0] d;
        logic [31:0] rd;
        time         t_prev;
        wait_sample();
        bus_write(op_addr(5, 1), 32'h0000_1234);
        check(32'(last_waits), 32'(4 * NUM_OPS + 1), "cycles held off by bus_wait");
        t_prev = last_accept;
        for (int k = 0; k < 3; k++) begin
            d = rand_bits(32);
            bus_write(op_addr(5, 1), d);
            check(32'(last_accept - t_prev), 32'(ROUND_CYCLES * CLK_PERIOD),
                  "one write per round");
            t_prev = last_accept;
            bus_read(op_addr(5, 1), rd);
            check(rd, d & 32'h0000_FF3F, "read-back after write");
        end
    endtask

    initial begin
        reset      = 1'b1;
        bus_addr   = '0;
        bus_wrdata = '0;
        bus_wren   = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        test_reset_readback();
        test_silence();
        test_single_tone();
        test_mix_clamp();
        test_envelope();
        test_backpressure();

        $display("Test passed");
        $finish;
    end

endmodule

/* compile.f */
hdl/fm_pkg.sv
hdl/fm_regs.sv
hdl/fm_phase.sv
hdl/fm_eg.sv
hdl/fm_op.sv
hdl/fmsynth.sv
bench/fmsynth_tb.sv

/* hdl/fm_eg.sv */
module fm_eg
    import fm_pkg::*;
#(
    parameter int NUM_OPS = 16
) (
    input  logic             clk,
    input  logic             reset,

    input  logic [3:0]       op_sel,
    input  logic             op_step,
    input  logic             restart,
    input  logic             kon,

    input  logic [3:0]       ar,
    input  logic [3:0]       rr,

    output logic [ATT_W-1:0] att
);

    typedef enum logic [1:0] {
        EG_IDLE,
        EG_ATTACK,
        EG_SUSTAIN,
        EG_RELEASE
    } eg_state_t;

    eg_state_t        state_mem [NUM_OPS];
    logic [ATT_W-1:0] att_mem [NUM_OPS];

    eg_state_t        cur_state;
    logic [ATT_W-1:0] cur_att;
    eg_state_t        next_state;
    logic [ATT_W-1:0] next_att;

    logic [ATT_W-1:0] ar_step;
    logic [ATT_W-1:0] rr_step;
    logic [ATT_W:0]   att_up;

    // Attack falls by ar*8, release rises by rr*2 per round
    assign ar_step = {2'b00, ar, 3'b000};
    assign rr_step = {4'b0000, rr, 1'b0};
    assign att_up  = {1'b0, cur_att} + {1'b0, rr_step};

    //////////////////////////////////////////////////
    // Envelope step
    //////////////////////////////////////////////////
    always_comb begin
        next_state = cur_state;
        next_att   = cur_att;

        if (restart) begin
            next_state = EG_ATTACK;
            next_att   = ATT_MAX;
        end else begin
            case (cur_state)
                EG_IDLE: begin
                    next_att = ATT_MAX;
                end

                EG_ATTACK: begin
                    if (!kon) begin
                        next_state = EG_RELEASE;
                    end else if (ar == 4'd15 || cur_att <= ar_step) begin
                        next_att   = '0;
                        next_state = EG_SUSTAIN;
                    end else begin
                        next_att = cur_att - ar_step;
                    end
                end

                EG_SUSTAIN: begin
                    if (!kon)
                        next_state = EG_RELEASE;
                end

                EG_RELEASE: begin
                    if (att_up >= {1'b0, ATT_MAX}) begin
                        next_att   = ATT_MAX;
                        next_state = EG_IDLE;
                    end else begin
                        next_att = att_up[ATT_W-1:0];
                    end
                end

                default: next_state = EG_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Per-operator storage
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_OPS; i++)
                state_mem[i] <= EG_IDLE;
            cur_state <= EG_IDLE;
        end else begin
            cur_state <= state_mem[op_sel];
            if (op_step)
                state_mem[op_sel] <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        cur_att <= att_mem[op_sel];
        if (op_step)
            att_mem[op_sel] <= next_att;
    end

    // An idle operator is always silent
    assign att = (cur_state == EG_IDLE) ? ATT_MAX : cur_att;

endmodule

/* hdl/fm_op.sv */
module fm_op
    import fm_pkg::*;
(
    input  logic                       clk,

    input  wave_t                      ws,
    input  logic [9:0]                 phase,
    input  logic [ATT_W-1:0]           att,
    input  logic [5:0]                 tl,

    output logic signed [SAMPLE_W-1:0] result
);

    logic signed [SAMPLE_W-1:0]     wave;
    logic signed [15:0]             tri_raw;
    logic signed [15:0]             phase_s;
    logic [ATT_W:0]                 att_total;
    logic [ATT_W-1:0]               gain;
    logic signed [SAMPLE_W+ATT_W:0] product;

    //////////////////////////////////////////////////
    // Waveform shaping
    //////////////////////////////////////////////////
    assign phase_s = $signed({6'd0, phase});

    always_comb begin
        if (phase < 10'd256)
            tri_raw = phase_s <<< 4;
        else if (phase < 10'd768)
            tri_raw = (16'sd512 - phase_s) <<< 4;
        else
            tri_raw = (phase_s - 16'sd1024) <<< 4;
    end

    always_comb begin
        case (ws)
            WS_SQUARE:      wave = phase[9] ? -WAVE_MAX : WAVE_MAX;
            WS_HALF_SQUARE: wave = phase[9] ? '0 : WAVE_MAX;
            // p - 512 is p with the top bit flipped, times 8
            WS_SAW:         wave = $signed({~phase[9], phase[8:0], 3'b000});
            WS_TRIANGLE: begin
                if (tri_raw > WAVE_MAX)
                    wave = WAVE_MAX;
                else if (tri_raw < -WAVE_MAX)
                    wave = -WAVE_MAX;
                else
                    wave = tri_raw[SAMPLE_W-1:0];
            end
            default:        wave = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Gain from attenuation and total level
    //////////////////////////////////////////////////
    assign att_total = {1'b0, att} + {1'b0, tl, 3'b000};
    assign gain = (att_total >= {1'b0, ATT_MAX}) ? '0 : ATT_MAX - att_total[ATT_W-1:0];

    assign product = wave * $signed({1'b0, gain});

    // Shift right by 9, the top bits are sign only
    always_ff @(posedge clk) begin
        result <= product[SAMPLE_W+ATT_W-1:ATT_W];
    end

endmodule

/* hdl/fm_phase.sv */
module fm_phase
    import fm_pkg::*;
#(
    parameter int NUM_OPS = 16
) (
    input  logic       clk,
    input  logic       reset,

    input  logic [3:0] op_sel,
    input  logic       op_step,
    input  logic       restart,

    input  logic [9:0] fnum,
    input  logic [2:0] block,
    input  logic [3:0] mult,

    output logic [9:0] phase
);

    logic [PHASE_W-1:0] phase_mem [NUM_OPS];
    logic [PHASE_W-1:0] cur_phase;
    logic [16:0]        base_inc;
    logic [20:0]        inc_mult;
    logic [PHASE_W-1:0] inc;
    logic [PHASE_W-1:0] next_phase;

    //////////////////////////////////////////////////
    // Phase increment
    //////////////////////////////////////////////////
    assign base_inc = {7'd0, fnum} << block;
    assign inc_mult = 21'(base_inc) * 21'(mult);

    // Multiplier 0 means one half
    assign inc = (mult == 4'd0) ? PHASE_W'(base_inc >> 1) : PHASE_W'(inc_mult);

    // Accumulator wraps at PHASE_W bits
    assign next_phase = restart ? '0 : cur_phase + inc;

    //////////////////////////////////////////////////
    // Accumulator memory
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (op_step)
            phase_mem[op_sel] <= next_phase;
    end

    // Registered read of the selected operator
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            cur_phase <= '0;
        else
            cur_phase <= phase_mem[op_sel];
    end

    assign phase = cur_phase[PHASE_W-1 -: 10];

endmodule

/* hdl/fm_pkg.sv */
package fm_pkg;

    //////////////////////////////////////////////////
    // Sequencer and waveform encodings
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ST_INIT,
        ST_FETCH,
        ST_WAVE,
        ST_MIX,
        ST_NEXT,
        ST_OUT,
        ST_BUS
    } seq_state_t;

    typedef enum logic [1:0] {
        WS_SQUARE      = 2'd0,
        WS_HALF_SQUARE = 2'd1,
        WS_SAW         = 2'd2,
        WS_TRIANGLE    = 2'd3
    } wave_t;

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////
    localparam int PHASE_W  = 19;
    localparam int ATT_W    = 9;
    localparam int SAMPLE_W = 13;
    localparam int ACC_W    = 19;

    // Silent attenuation and peak wave amplitude
    localparam logic [ATT_W-1:0]           ATT_MAX  = 9'd511;
    localparam logic signed [SAMPLE_W-1:0] WAVE_MAX = 13'sd4095;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////
    localparam logic [7:0] ADDR_KON     = 8'd0;
    localparam logic [7:0] ADDR_OP_BASE = 8'd16;

    // Operator word 0
    localparam int FNUM_LSB  = 0;
    localparam int BLOCK_LSB = 10;
    localparam int MULT_LSB  = 13;
    localparam int WS_LSB    = 17;
    localparam int PAN_L_BIT = 19;
    localparam int PAN_R_BIT = 20;

    // Operator word 1
    localparam int TL_LSB = 0;
    localparam int AR_LSB = 8;
    localparam int RR_LSB = 12;

    // Implemented bits of each word
    localparam logic [31:0] WORD0_MASK = 32'h001F_FFFF;
    localparam logic [31:0] WORD1_MASK = 32'h0000_FF3F;

endpackage

/* hdl/fm_regs.sv */
module fm_regs
    import fm_pkg::*;
#(
    parameter int NUM_OPS = 16
) (
    input  logic        clk,
    input  logic        reset,

    input  logic [7:0]  bus_addr,
    input  logic [31:0] bus_wrdata,
    input  logic        bus_wr,
    output logic [31:0] bus_rddata,

    input  logic [3:0]  op_sel,
    input  logic        op_step,

    output logic [9:0]  fnum,
    output logic [2:0]  block,
    output logic [3:0]  mult,
    output wave_t       ws,
    output logic        pan_l,
    output logic        pan_r,
    output logic [5:0]  tl,
    output logic [3:0]  ar,
    output logic [3:0]  rr,
    output logic        kon,
    output logic        restart
);

    logic [31:0]        word0 [NUM_OPS];
    logic [31:0]        word1 [NUM_OPS];
    logic [NUM_OPS-1:0] kon_bits;
    logic [NUM_OPS-1:0] restart_bits;
    logic [NUM_OPS-1:0] restart_next;
    logic [7:0]         op_off;
    logic [3:0]         addr_op;
    logic               sel_kon;
    logic               sel_op;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////
    assign sel_kon = (bus_addr == ADDR_KON);
    assign op_off  = bus_addr - ADDR_OP_BASE;
    assign sel_op  = (bus_addr >= ADDR_OP_BASE) && (op_off < 8'(2 * NUM_OPS));
    // Two words per operator, low bit picks the word
    assign addr_op = op_off[4:1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_OPS; i++) begin
                word0[i] <= '0;
                word1[i] <= '0;
            end
        end else if (bus_wr && sel_op) begin
            if (op_off[0])
                word1[addr_op] <= bus_wrdata & WORD1_MASK;
            else
                word0[addr_op] <= bus_wrdata & WORD0_MASK;
        end
    end

    //////////////////////////////////////////////////
    // Key-on and restart flags
    //////////////////////////////////////////////////
    always_comb begin
        restart_next = restart_bits;
        if (op_step)
            restart_next[op_sel] = 1'b0;
        // Rising key-on bits request a restart
        if (bus_wr && sel_kon)
            restart_next = restart_next | (bus_wrdata[NUM_OPS-1:0] & ~kon_bits);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            kon_bits     <= '0;
            restart_bits <= '0;
        end else begin
            restart_bits <= restart_next;
            if (bus_wr && sel_kon)
                kon_bits <= bus_wrdata[NUM_OPS-1:0];
        end
    end

    always_comb begin
        bus_rddata = '0;
        if (sel_kon)
            bus_rddata = 32'(kon_bits);
        else if (sel_op)
            bus_rddata = op_off[0] ? word1[addr_op] : word0[addr_op];
    end

    // Attributes of the operator being processed
    assign fnum    = word0[op_sel][FNUM_LSB +: 10];
    assign block   = word0[op_sel][BLOCK_LSB +: 3];
    assign mult    = word0[op_sel][MULT_LSB +: 4];
    assign ws      = wave_t'(word0[op_sel][WS_LSB +: 2]);
    assign pan_l   = word0[op_sel][PAN_L_BIT];
    assign pan_r   = word0[op_sel][PAN_R_BIT];
    assign tl      = word1[op_sel][TL_LSB +: 6];
    assign ar      = word1[op_sel][AR_LSB +: 4];
    assign rr      = word1[op_sel][RR_LSB +: 4];
    assign kon     = kon_bits[op_sel];
    assign restart = restart_bits[op_sel];

endmodule

/* hdl/fmsynth.sv */
module fmsynth
    import fm_pkg::*;
#(
    parameter int NUM_OPS = 16
) (
    input  logic        clk,
    input  logic        reset,

    input  logic [7:0]  bus_addr,
    input  logic [31:0] bus_wrdata,
    input  logic        bus_wren,
    output logic [31:0] bus_rddata,
    output logic        bus_wait,

    output logic [15:0] audio_l,
    output logic [15:0] audio_r,
    output logic        sample_valid
);

    seq_state_t                 state;
    logic [3:0]                 op_sel;
    logic                       op_step;
    logic                       last_op;
    logic                       bus_wr;

    logic [9:0]                 fnum;
    logic [2:0]                 block;
    logic [3:0]                 mult;
    wave_t                      ws;
    logic                       pan_l;
    logic                       pan_r;
    logic [5:0]                 tl;
    logic [3:0]                 ar;
    logic [3:0]                 rr;
    logic                       kon;
    logic                       restart;
    logic                       phase_restart;

    logic [9:0]                 phase;
    logic [ATT_W-1:0]           att;
    logic signed [SAMPLE_W-1:0] result;
    logic signed [ACC_W-1:0]    result_ext;
    logic signed [ACC_W-1:0]    acc_l;
    logic signed [ACC_W-1:0]    acc_r;

    function automatic logic [15:0] clamp16(input logic signed [ACC_W-1:0] sum);
        if (sum > 19'sd32767)
            return 16'h7FFF;
        else if (sum < -19'sd32768)
            return 16'h8000;
        return sum[15:0];
    endfunction

    // Writes only land in the bus slot of each round
    assign bus_wait = bus_wren && (state != ST_BUS);
    assign bus_wr   = bus_wren && (state == ST_BUS);

    // Init reuses the write-back path to clear every operator
    assign op_step       = (state == ST_MIX) || (state == ST_INIT);
    assign phase_restart = restart || (state == ST_INIT);
    assign last_op       = (op_sel == 4'(NUM_OPS - 1));
    assign result_ext    = {{(ACC_W - SAMPLE_W){result[SAMPLE_W-1]}}, result};

    //////////////////////////////////////////////////
    // Operator blocks
    //////////////////////////////////////////////////
    fm_regs #(.NUM_OPS(NUM_OPS)) u_regs (
        .clk        (clk),
        .reset      (reset),
        .bus_addr   (bus_addr),
        .bus_wrdata (bus_wrdata),
        .bus_wr     (bus_wr),
        .bus_rddata (bus_rddata),
        .op_sel     (op_sel),
        .op_step    (op_step),
        .fnum       (fnum),
        .block      (block),
        .mult       (mult),
        .ws         (ws),
        .pan_l      (pan_l),
        .pan_r      (pan_r),
        .tl         (tl),
        .ar         (ar),
        .rr         (rr),
        .kon        (kon),
        .restart    (restart)
    );

    fm_phase #(.NUM_OPS(NUM_OPS)) u_phase (
        .clk     (clk),
        .reset   (reset),
        .op_sel  (op_sel),
        .op_step (op_step),
        .restart (phase_restart),
        .fnum    (fnum),
        .block   (block),
        .mult    (mult),
        .phase   (phase)
    );

    fm_eg #(.NUM_OPS(NUM_OPS)) u_eg (
        .clk     (clk),
        .reset   (reset),
        .op_sel  (op_sel),
        .op_step (op_step),
        .restart (restart),
        .kon     (kon),
        .ar      (ar),
        .rr      (rr),
        .att     (att)
    );

    fm_op u_op (
        .clk    (clk),
        .ws     (ws),
        .phase  (phase),
        .att    (att),
        .tl     (tl),
        .result (result)
    );

    //////////////////////////////////////////////////
    // Sequencer and stereo mix
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= ST_INIT;
            op_sel       <= '0;
            acc_l        <= '0;
            acc_r        <= '0;
            audio_l      <= '0;
            audio_r      <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;

            case (state)
                ST_INIT: begin
                    op_sel <= op_sel + 4'd1;
                    if (last_op) begin
                        op_sel <= '0;
                        state  <= ST_FETCH;
                    end
                end

                ST_FETCH: state <= ST_WAVE;

                ST_WAVE: state <= ST_MIX;

                ST_MIX: begin
                    if (pan_l)
                        acc_l <= acc_l + result_ext;
                    if (pan_r)
                        acc_r <= acc_r + result_ext;
                    state <= ST_NEXT;
                end

                ST_NEXT: begin
                    if (last_op) begin
                        state <= ST_OUT;
                    end else begin
                        op_sel <= op_sel + 4'd1;
                        state  <= ST_FETCH;
                    end
                end

                ST_OUT: begin
                    audio_l      <= clamp16(acc_l);
                    audio_r      <= clamp16(acc_r);
                    sample_valid <= 1'b1;
                    acc_l        <= '0;
                    acc_r        <= '0;
                    state        <= ST_BUS;
                end

                ST_BUS: begin
                    op_sel <= '0;
                    state  <= ST_FETCH;
                end

                default: state <= ST_INIT;
            endcase
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the fmsynth testbench with Verilator
verilator --binary --timing --top-module fmsynth_tb -f compile.f -o fmsynth_sim \
    && ./obj_dir/fmsynth_sim \
    || { echo "Simulation failed"; exit 1; }
